// File: hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // first fetch address after reset
  localparam logic [31:0] reset_pc = 32'h8000_0000;

  // data and address width
  localparam int xlen = 32;

  // cache geometry, both powers of two
  localparam int line_words = 4;
  localparam int cache_lines = 16;

  // pc split: tag | index | word | byte
  localparam int word_bits = $clog2(line_words);
  localparam int index_bits = $clog2(cache_lines);
  localparam int tag_bits = xlen - index_bits - word_bits - 2;

  // major opcodes, inst[6:2]
  localparam logic [4:0] opcode_branch = 5'b11000;
  localparam logic [4:0] opcode_jal = 5'b11011;

  // one instruction word, seen as B-type or as J-type
  typedef union packed {
    struct packed {
      logic       sign;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [4:0] opcode;
      logic [1:0] quadrant;
    } b_view;
    struct packed {
      logic       sign;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [4:0] opcode;
      logic [1:0] quadrant;
    } j_view;
  } inst_u;

endpackage

`default_nettype wire

// File: hdl/redirect_merge.sv
`timescale 1ns/1ns
`default_nettype none

module redirect_merge (
  input  logic        clock,
  input  logic        reset,
  input  logic        jump_flush,
  input  logic [31:0] jump_dnpc,
  input  logic        cs_flush,
  input  logic [31:0] cs_dnpc,
  input  logic        hit,
  output logic        redirect,
  output logic        redirect_now,
  output logic [31:0] redirect_pc
);

  // redirect waiting for the cache to hit
  logic        pending;
  logic [31:0] pending_pc;
  // target of this cycle's pulse
  logic [31:0] pulse_pc;

  // exception side wins over jump
  assign pulse_pc = cs_flush ? cs_dnpc : jump_dnpc;
  assign redirect_now = jump_flush | cs_flush;

  // a fresh pulse overrides an older held target
  assign redirect = redirect_now | pending;
  assign redirect_pc = redirect_now ? pulse_pc : pending_pc;

  // hold until fetch pc can actually move
  always_ff @(posedge clock) begin
    if (reset) begin
      pending <= 1'b0;
    end else begin
      pending <= redirect & ~hit;
    end
  end

  always_ff @(posedge clock) begin
    if (redirect_now) begin
      pending_pc <= pulse_pc;
    end
  end

endmodule

`default_nettype wire

// File: hdl/icache.sv
`timescale 1ns/1ns
`default_nettype none

module icache (
  input  logic        clock,
  input  logic        reset,
  input  logic        fencei,
  input  logic [31:0] fetch_pc,
  output logic        hit,
  output logic [31:0] inst,
  output logic        mem_req,
  output logic [31:0] mem_addr,
  input  logic        mem_resp,
  input  logic [31:0] mem_data
);

  // fields of the fetch pc
  logic [fetch_pkg::tag_bits-1:0]   pc_tag;
  logic [fetch_pkg::index_bits-1:0] pc_index;
  logic [fetch_pkg::word_bits-1:0]  pc_word;

  // line storage
  logic [31:0] data_array [fetch_pkg::cache_lines][fetch_pkg::line_words];
  logic [fetch_pkg::tag_bits-1:0] tag_array [fetch_pkg::cache_lines];
  logic [fetch_pkg::cache_lines-1:0] valid;

  // refill state
  logic busy;
  logic killed;
  logic start;
  logic last_word;
  logic [fetch_pkg::word_bits-1:0]  count;
  logic [fetch_pkg::tag_bits-1:0]   refill_tag;
  logic [fetch_pkg::index_bits-1:0] refill_index;

  assign {pc_tag, pc_index, pc_word} = fetch_pc[31:2];

  // lookup is purely combinational
  assign hit = valid[pc_index] && (tag_array[pc_index] == pc_tag);
  assign inst = data_array[pc_index][pc_word];

  // miss seen while idle starts a refill
  assign start = ~busy & ~hit;
  // line_words is a power of two, so all ones marks the last word
  assign last_word = (count == {fetch_pkg::word_bits{1'b1}});
  assign mem_addr = {refill_tag, refill_index, count, 2'b00};

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= 1'b0;
      killed <= 1'b0;
      mem_req <= 1'b0;
      count <= '0;
      valid <= '0;
    end else begin
      // request is a one cycle strobe
      mem_req <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        killed <= 1'b0;
        count <= '0;
        mem_req <= 1'b1;
        // victim line is overwritten word by word
        valid[pc_index] <= 1'b0;
      end else if (busy && mem_resp) begin
        if (last_word) begin
          busy <= 1'b0;
          valid[refill_index] <= ~killed;
        end else begin
          // next word only after the previous response
          count <= count + 1'b1;
          mem_req <= 1'b1;
        end
      end
      // fence.i drops every line, in-flight one stays invalid
      if (fencei) begin
        valid <= '0;
        if (busy) begin
          killed <= 1'b1;
        end
      end
    end
  end

  // line address captured once per refill
  always_ff @(posedge clock) begin
    if (start) begin
      refill_tag <= pc_tag;
      refill_index <= pc_index;
    end
    if (busy && mem_resp) begin
      data_array[refill_index][count] <= mem_data;
      if (last_word) begin
        tag_array[refill_index] <= refill_tag;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/branch_predict.sv
`timescale 1ns/1ns
`default_nettype none

module branch_predict (
  input  logic [31:0] fetch_pc,
  input  logic [31:0] inst,
  output logic [31:0] pred_pc
);

  fetch_pkg::inst_u word;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic [31:0] step;
  logic        take_branch;
  logic        take_jal;

  assign word = inst;

  // B-type immediate, bit 0 always zero
  assign imm_b = {{20{word.b_view.sign}}, word.b_view.imm_11,
                  word.b_view.imm_10_5, word.b_view.imm_4_1, 1'b0};

  // J-type immediate, 21 bits signed
  assign imm_j = {{12{word.j_view.sign}}, word.j_view.imm_19_12,
                  word.j_view.imm_11, word.j_view.imm_10_1, 1'b0};

  // backward taken: sign bit set means negative offset
  assign take_branch = (word.b_view.opcode == fetch_pkg::opcode_branch) & word.b_view.sign;
  // jal is always taken
  assign take_jal = (word.j_view.opcode == fetch_pkg::opcode_jal);

  always_comb begin
    if (take_branch) begin
      step = imm_b;
    end else if (take_jal) begin
      step = imm_j;
    end else begin
      step = 32'd4;
    end
  end

  assign pred_pc = fetch_pc + step;

endmodule

`default_nettype wire

// File: hdl/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
  input  logic        clock,
  input  logic        reset,
  input  logic        hit,
  input  logic [31:0] inst,
  input  logic [31:0] pred_pc,
  input  logic        redirect,
  input  logic        redirect_now,
  input  logic [31:0] redirect_pc,
  input  logic        out_ready,
  output logic [31:0] fetch_pc,
  output logic        out_valid,
  output logic [31:0] out_pc,
  output logic [31:0] out_inst
);

  // output register holds a word
  logic out_valid_r;
  // output register free or being drained this cycle
  logic step_en;
  // capture the cache word into the output register
  logic load;

  assign step_en = ~out_valid_r | out_ready;
  assign load = hit & step_en & ~redirect;

  // word in the register is stale once a redirect pulse lands
  assign out_valid = out_valid_r & ~redirect_now;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid_r <= 1'b0;
      fetch_pc <= fetch_pkg::reset_pc;
    end else begin
      // redirect empties the output register
      if (redirect) begin
        out_valid_r <= 1'b0;
      end else if (step_en) begin
        out_valid_r <= hit;
      end
      // pc only moves on a hit
      if (hit) begin
        if (redirect) begin
          fetch_pc <= redirect_pc;
        end else if (step_en) begin
          fetch_pc <= pred_pc;
        end
      end
    end
  end

  // pc/inst pair, held under back-pressure
  always_ff @(posedge clock) begin
    if (load) begin
      out_pc <= fetch_pc;
      out_inst <= inst;
    end
  end

endmodule

`default_nettype wire

// File: hdl/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top (
  input  logic        clock,
  input  logic        reset,
  input  logic        jump_flush,
  input  logic [31:0] jump_dnpc,
  input  logic        cs_flush,
  input  logic [31:0] cs_dnpc,
  input  logic        fencei,
  input  logic        out_ready,
  output logic        out_valid,
  output logic [31:0] out_pc,
  output logic [31:0] out_inst,
  output logic        mem_req,
  output logic [31:0] mem_addr,
  input  logic        mem_resp,
  input  logic [31:0] mem_data
);

  // cache lookup result
  logic                      hit;
  logic [fetch_pkg::xlen-1:0] cache_inst;
  // pc path
  logic [fetch_pkg::xlen-1:0] fetch_pc;
  logic [fetch_pkg::xlen-1:0] pred_pc;
  // merged redirect
  logic                      redirect;
  logic                      redirect_now;
  logic [fetch_pkg::xlen-1:0] redirect_pc;

  redirect_merge u_redirect_merge (
    .clock        (clock),
    .reset        (reset),
    .jump_flush   (jump_flush),
    .jump_dnpc    (jump_dnpc),
    .cs_flush     (cs_flush),
    .cs_dnpc      (cs_dnpc),
    .hit          (hit),
    .redirect     (redirect),
    .redirect_now (redirect_now),
    .redirect_pc  (redirect_pc)
  );

  icache u_icache (
    .clock    (clock),
    .reset    (reset),
    .fencei   (fencei),
    .fetch_pc (fetch_pc),
    .hit      (hit),
    .inst     (cache_inst),
    .mem_req  (mem_req),
    .mem_addr (mem_addr),
    .mem_resp (mem_resp),
    .mem_data (mem_data)
  );

  // static next pc from the word under fetch
  branch_predict u_branch_predict (
    .fetch_pc (fetch_pc),
    .inst     (cache_inst),
    .pred_pc  (pred_pc)
  );

  fetch_stage u_fetch_stage (
    .clock        (clock),
    .reset        (reset),
    .hit          (hit),
    .inst         (cache_inst),
    .pred_pc      (pred_pc),
    .redirect     (redirect),
    .redirect_now (redirect_now),
    .redirect_pc  (redirect_pc),
    .out_ready    (out_ready),
    .fetch_pc     (fetch_pc),
    .out_valid    (out_valid),
    .out_pc       (out_pc),
    .out_inst     (out_inst)
  );

endmodule

`default_nettype wire

// File: dv/imem_model.sv
`timescale 1ns/1ns
`default_nettype none

module imem_model (
  input  logic        clock,
  input  logic        reset,
  input  logic        mem_req,
  input  logic [31:0] mem_addr,
  input  logic [1:0]  lat_sel,
  output logic        mem_resp,
  output logic [31:0] mem_data
);

  // one request in flight at a time
  logic        busy;
  logic [1:0]  wait_left;
  logic [31:0] req_addr;

  // contents by address rule
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    // word 7 of a 64-byte block, bit 7 clear: beq x0, x0, -8
    if (addr[5:2] == 4'd7 && !addr[7]) begin
      return 32'hfe00_0ce3;
    end
    // word 13: jal x0, +16
    if (addr[5:2] == 4'd13) begin
      return 32'h0100_006f;
    end
    // everything else is a nop
    return 32'h0000_0013;
  endfunction

  initial begin
    mem_resp = 1'b0;
    mem_data = 32'h0;
  end

  always @(posedge clock) begin
    if (reset) begin
      busy <= 1'b0;
      mem_resp <= 1'b0;
    end else begin
      // response is a one cycle strobe
      mem_resp <= 1'b0;
      if (mem_req) begin
        busy <= 1'b1;
        wait_left <= lat_sel;
        req_addr <= mem_addr;
      end else if (busy) begin
        // latency 1 to 4 cycles
        if (wait_left == 2'd0) begin
          mem_resp <= 1'b1;
          mem_data <= word_at(req_addr);
          busy <= 1'b0;
        end else begin
          wait_left <= wait_left - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/fetch_monitor.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_monitor (
  input  logic         clock,
  input  logic         reset,
  input  logic         out_valid,
  input  logic         out_ready,
  input  logic [31:0]  out_pc,
  input  logic [31:0]  out_inst,
  input  logic         mem_req,
  input  logic [31:0]  mem_addr,
  input  logic         jump_flush,
  input  logic [31:0]  jump_dnpc,
  input  logic         cs_flush,
  input  logic [31:0]  cs_dnpc,
  input  logic [127:0] test_name,
  input  logic         need_refill,
  input  logic         test_end,
  output int           total_errors,
  output int           total_transfers,
  output int           total_misses
);

  // pc the next transfer must carry
  logic [31:0] exp_pc;
  // per test counts
  int t_transfers;
  int t_misses;
  int t_errors;

  // memory rule, kept apart from the responder
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    if (addr[5:2] == 4'd7 && !addr[7]) begin
      return 32'hfe00_0ce3;
    end
    if (addr[5:2] == 4'd13) begin
      return 32'h0100_006f;
    end
    return 32'h0000_0013;
  endfunction

  // static prediction applied to the expected word
  function automatic logic [31:0] next_pc(input logic [31:0] pc);
    fetch_pkg::inst_u w;
    w = word_at(pc);
    // backward branch in memory is always -8
    if (w.b_view.opcode == fetch_pkg::opcode_branch && w.b_view.sign) begin
      return pc - 32'd8;
    end
    // the only jal in memory jumps +16
    if (w.j_view.opcode == fetch_pkg::opcode_jal) begin
      return pc + 32'd16;
    end
    return pc + 32'd4;
  endfunction

  initial begin
    total_errors = 0;
    total_transfers = 0;
    total_misses = 0;
  end

  always @(posedge clock) begin
    if (reset) begin
      exp_pc = fetch_pkg::reset_pc;
      t_transfers = 0;
      t_misses = 0;
      t_errors = 0;
    end else begin
      if (out_valid && out_ready) begin
        t_transfers++;
        if (out_pc !== exp_pc) begin
          $display("CHECK FAILED %0s: pc expected %h actual %h", test_name, exp_pc, out_pc);
          t_errors++;
        end
        if (out_inst !== word_at(exp_pc)) begin
          $display("CHECK FAILED %0s: inst at %h expected %h actual %h",
                   test_name, exp_pc, word_at(exp_pc), out_inst);
          t_errors++;
        end
        exp_pc = next_pc(exp_pc);
      end
      // redirect target replaces the predicted stream, cs first
      if (jump_flush || cs_flush) begin
        exp_pc = cs_flush ? cs_dnpc : jump_dnpc;
      end
      // first word request of a line marks one miss
      if (mem_req && mem_addr[2 +: fetch_pkg::word_bits] == '0) begin
        t_misses++;
      end
      if (test_end) begin
        if (t_transfers == 0) begin
          $display("test %0s: no instruction was transferred", test_name);
          t_errors++;
        end
        if (need_refill && t_misses == 0) begin
          $display("test %0s: a cache refill was due but memory saw no request", test_name);
          t_errors++;
        end
        $display("test %0s: %0d transfers, %0d misses, %0d errors",
                 test_name, t_transfers, t_misses, t_errors);
        total_errors += t_errors;
        total_transfers += t_transfers;
        total_misses += t_misses;
        t_transfers = 0;
        t_misses = 0;
        t_errors = 0;
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/fetch_checker.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_checker (
  input logic        clock,
  input logic        reset,
  input logic        out_valid,
  input logic        out_ready,
  input logic [31:0] out_pc,
  input logic [31:0] out_inst,
  input logic        redirect,
  input logic        mem_req,
  input logic        mem_resp
);

  // refill word requested and not yet answered
  logic outstanding;
  // bumped by every failing assertion
  int fail_count = 0;

  always @(posedge clock) begin
    if (reset) begin
      outstanding <= 1'b0;
    end else if (mem_req) begin
      outstanding <= 1'b1;
    end else if (mem_resp) begin
      outstanding <= 1'b0;
    end
  end

  // output pair frozen under back-pressure
  hold_stable: assert property (@(posedge clock) disable iff (reset)
      out_valid && !out_ready |=> $stable(out_pc) && $stable(out_inst))
    else begin
      $error("output pair changed while out_valid was high and out_ready low");
      fail_count++;
    end

  // output register emptied by every redirect cycle
  redirect_mask: assert property (@(posedge clock) disable iff (reset)
      redirect |=> !out_valid)
    else begin
      $error("out_valid high in the cycle after a redirect");
      fail_count++;
    end

  // one refill request at a time
  single_request: assert property (@(posedge clock) disable iff (reset)
      mem_req |-> !outstanding)
    else begin
      $error("mem_req raised while an earlier request was unanswered");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: dv/fetch_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_tb;

  logic         clock;
  logic         reset;
  logic         jump_flush;
  logic [31:0]  jump_dnpc;
  logic         cs_flush;
  logic [31:0]  cs_dnpc;
  logic         fencei;
  logic         out_ready;
  logic         out_valid;
  logic [31:0]  out_pc;
  logic [31:0]  out_inst;
  logic         mem_req;
  logic [31:0]  mem_addr;
  logic         mem_resp;
  logic [31:0]  mem_data;
  // memory latency pick 0..3 for 1..4 cycles
  logic [1:0]   lat_sel;
  // current test as seen by the monitor
  logic [127:0] test_name;
  logic         need_refill;
  logic         test_end;
  int           total_errors;
  int           total_transfers;
  int           total_misses;
  int           cycle_count;
  int           cycle_limit;
  logic [7:0]   lfsr_state;

  // test table
  logic [127:0] name_tab [5] = '{"straight", "jump_jal", "random_ready",
                                 "cs_over_jump", "fence_refetch"};
  int           cycles_tab [5] = '{100, 260, 150, 140, 200};
  // out_ready from the lfsr or held high
  logic         ready_tab [5] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
  // redirect kind with bit 0 jump and bit 1 cs
  logic [1:0]   redirect_tab [5] = '{2'b00, 2'b01, 2'b00, 2'b11, 2'b01};
  // fence test returns to the block cached by the cs test
  logic [31:0]  jump_tab [5] = '{32'h0, 32'h8000_0080, 32'h0, 32'h8000_0040, 32'h8000_0200};
  logic [31:0]  cs_tab [5] = '{32'h0, 32'h0, 32'h0, 32'h8000_0200, 32'h0};
  logic         fencei_tab [5] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
  // at least one line refill expected during the test
  logic         refill_tab [5] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1};

  fetch_top DUT (
    .clock      (clock),
    .reset      (reset),
    .jump_flush (jump_flush),
    .jump_dnpc  (jump_dnpc),
    .cs_flush   (cs_flush),
    .cs_dnpc    (cs_dnpc),
    .fencei     (fencei),
    .out_ready  (out_ready),
    .out_valid  (out_valid),
    .out_pc     (out_pc),
    .out_inst   (out_inst),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_resp   (mem_resp),
    .mem_data   (mem_data)
  );

  imem_model mem (
    .clock    (clock),
    .reset    (reset),
    .mem_req  (mem_req),
    .mem_addr (mem_addr),
    .lat_sel  (lat_sel),
    .mem_resp (mem_resp),
    .mem_data (mem_data)
  );

  fetch_monitor monitor (
    .clock           (clock),
    .reset           (reset),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .out_pc          (out_pc),
    .out_inst        (out_inst),
    .mem_req         (mem_req),
    .mem_addr        (mem_addr),
    .jump_flush      (jump_flush),
    .jump_dnpc       (jump_dnpc),
    .cs_flush        (cs_flush),
    .cs_dnpc         (cs_dnpc),
    .test_name       (test_name),
    .need_refill     (need_refill),
    .test_end        (test_end),
    .total_errors    (total_errors),
    .total_transfers (total_transfers),
    .total_misses    (total_misses)
  );

  // assertions see the top level ports plus the merged redirect
  bind fetch_top fetch_checker u_fetch_checker (
    .clock     (clock),
    .reset     (reset),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_pc    (out_pc),
    .out_inst  (out_inst),
    .redirect  (redirect),
    .mem_req   (mem_req),
    .mem_resp  (mem_resp)
  );

  always #2 clock = ~clock;

  // fibonacci lfsr with taps 8 6 5 4
  function automatic logic [7:0] lfsr_next(input logic [7:0] state);
    return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
  endfunction

  // one lfsr step per random bit
  task automatic draw_bit(output logic b);
    lfsr_state = lfsr_next(lfsr_state);
    b = lfsr_state[0];
  endtask

  // inputs for one cycle of a table row
  task automatic drive_cycle(input int row, input int c);
    logic lat_hi;
    logic lat_lo;
    logic rdy;
    draw_bit(lat_hi);
    draw_bit(lat_lo);
    lat_sel <= {lat_hi, lat_lo};
    if (ready_tab[row]) begin
      draw_bit(rdy);
      out_ready <= rdy;
    end else begin
      out_ready <= 1'b1;
    end
    // fence.i first so the redirect two cycles later lands inside the refill
    fencei <= fencei_tab[row] && (c == 0);
    jump_flush <= redirect_tab[row][0] && (c == 2);
    cs_flush <= redirect_tab[row][1] && (c == 2);
    jump_dnpc <= jump_tab[row];
    cs_dnpc <= cs_tab[row];
    test_name <= name_tab[row];
    need_refill <= refill_tab[row];
    test_end <= (c == cycles_tab[row] - 1);
  endtask

  // run guard
  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the run did not end within %0d cycles", cycle_limit);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    jump_flush = 1'b0;
    jump_dnpc = 32'h0;
    cs_flush = 1'b0;
    cs_dnpc = 32'h0;
    fencei = 1'b0;
    out_ready = 1'b0;
    lat_sel = 2'd0;
    test_name = name_tab[0];
    need_refill = 1'b0;
    test_end = 1'b0;
    lfsr_state = 8'd54;
    cycle_count = 0;
    // reset and closing cycles plus one worst case line refill per test
    cycle_limit = 3 + 10;
    for (int i = 0; i < $size(cycles_tab); i++) begin
      cycle_limit += cycles_tab[i] + fetch_pkg::line_words * 6;
    end

    repeat (3) @(posedge clock);
    reset <= 1'b0;
    for (int i = 0; i < $size(cycles_tab); i++) begin
      for (int c = 0; c < cycles_tab[i]; c++) begin
        drive_cycle(i, c);
        @(posedge clock);
      end
    end
    // quiet cycle so the monitor closes the last test
    test_end <= 1'b0;
    jump_flush <= 1'b0;
    cs_flush <= 1'b0;
    fencei <= 1'b0;
    @(posedge clock);

    $display("summary: %0d tests, %0d transfers, %0d misses, %0d errors, %0d assertion failures",
             $size(cycles_tab), total_transfers, total_misses, total_errors,
             DUT.u_fetch_checker.fail_count);
    if (total_errors == 0 && DUT.u_fetch_checker.fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
hdl/fetch_pkg.sv
hdl/redirect_merge.sv
hdl/icache.sv
hdl/branch_predict.sv
hdl/fetch_stage.sv
hdl/fetch_top.sv
dv/imem_model.sv
dv/fetch_monitor.sv
dv/fetch_checker.sv
dv/fetch_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the fetch testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fetch_tb -f project.f -o fetch_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/fetch_sim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
